// ==== logic/riscv_isa_pkg.sv ====
package riscv_isa_pkg;

	localparam int XLEN       = 32;
	localparam int REG_ADDR_W = 5;

	typedef logic [XLEN-1:0]       word_t;
	typedef logic [31:0]           inst_t;
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;
	typedef logic [6:0]            opcode_t;
	typedef logic [2:0]            funct3_t;
	typedef logic [6:0]            funct7_t;

	// instruction field positions
	localparam int RD_LSB  = 7;
	localparam int F3_LSB  = 12;
	localparam int RS1_LSB = 15;
	localparam int RS2_LSB = 20;
	localparam int F7_LSB  = 25;
	localparam int IMM_LSB = 20; // I-type immediate, also shamt
	localparam int U_LSB   = 12;

	// major opcodes
	localparam opcode_t OPC_OP     = 7'b0110011;
	localparam opcode_t OPC_OP_IMM = 7'b0010011;
	localparam opcode_t OPC_BRANCH = 7'b1100011;
	localparam opcode_t OPC_LOAD   = 7'b0000011;
	localparam opcode_t OPC_STORE  = 7'b0100011;
	localparam opcode_t OPC_LUI    = 7'b0110111;
	localparam opcode_t OPC_AUIPC  = 7'b0010111;
	localparam opcode_t OPC_JAL    = 7'b1101111;
	localparam opcode_t OPC_JALR   = 7'b1100111;

	// OP / OP_IMM
	localparam funct3_t F3_ADD_SUB = 3'b000;
	localparam funct3_t F3_SLL     = 3'b001;
	localparam funct3_t F3_SLT     = 3'b010;
	localparam funct3_t F3_SLTU    = 3'b011;
	localparam funct3_t F3_XOR     = 3'b100;
	localparam funct3_t F3_SRL_SRA = 3'b101;
	localparam funct3_t F3_OR      = 3'b110;
	localparam funct3_t F3_AND     = 3'b111;

	// conditional branches
	localparam funct3_t F3_BEQ  = 3'b000;
	localparam funct3_t F3_BNE  = 3'b001;
	localparam funct3_t F3_BLT  = 3'b100;
	localparam funct3_t F3_BGE  = 3'b101;
	localparam funct3_t F3_BLTU = 3'b110;
	localparam funct3_t F3_BGEU = 3'b111;

	// loads and stores
	localparam funct3_t F3_LB  = 3'b000;
	localparam funct3_t F3_LH  = 3'b001;
	localparam funct3_t F3_LW  = 3'b010;
	localparam funct3_t F3_LBU = 3'b100;
	localparam funct3_t F3_LHU = 3'b101;
	localparam funct3_t F3_SB  = 3'b000;
	localparam funct3_t F3_SH  = 3'b001;
	localparam funct3_t F3_SW  = 3'b010;
	localparam funct3_t F3_JALR = 3'b000;

	localparam funct7_t F7_BASE = 7'b0000000;
	localparam funct7_t F7_ALT  = 7'b0100000; // SUB, SRA, SRAI

	localparam reg_addr_t LINK_REG   = 5'd1; // ra
	localparam word_t     INST_BYTES = 32'd4;

endpackage

// ==== logic/id_stage_pkg.sv ====
package id_stage_pkg;

	typedef logic [4:0] alu_op_t;
	typedef logic [2:0] alu_sel_t;
	typedef logic [3:0] br_kind_t; // nine kinds, does not fit in 3 bits

	localparam alu_op_t ALU_NOP  = 5'd0;
	localparam alu_op_t ALU_OR   = 5'd1;
	localparam alu_op_t ALU_AND  = 5'd2;
	localparam alu_op_t ALU_XOR  = 5'd3;
	localparam alu_op_t ALU_SLL  = 5'd4;
	localparam alu_op_t ALU_SRL  = 5'd5;
	localparam alu_op_t ALU_SRA  = 5'd6;
	localparam alu_op_t ALU_ADD  = 5'd7;
	localparam alu_op_t ALU_SUB  = 5'd8;
	localparam alu_op_t ALU_SLT  = 5'd9;
	localparam alu_op_t ALU_SLTU = 5'd10;
	localparam alu_op_t ALU_LB   = 5'd11;
	localparam alu_op_t ALU_LH   = 5'd12;
	localparam alu_op_t ALU_LBU  = 5'd13;
	localparam alu_op_t ALU_LHU  = 5'd14;
	localparam alu_op_t ALU_LW   = 5'd15;
	localparam alu_op_t ALU_SB   = 5'd16;
	localparam alu_op_t ALU_SH   = 5'd17;
	localparam alu_op_t ALU_SW   = 5'd18;
	localparam alu_op_t ALU_BEQ  = 5'd19;
	localparam alu_op_t ALU_BNE  = 5'd20;
	localparam alu_op_t ALU_BLT  = 5'd21;
	localparam alu_op_t ALU_BGE  = 5'd22;
	localparam alu_op_t ALU_BLTU = 5'd23;
	localparam alu_op_t ALU_BGEU = 5'd24;
	localparam alu_op_t ALU_JAL  = 5'd25;
	localparam alu_op_t ALU_JALR = 5'd26;

	// result class seen by execute
	localparam alu_sel_t SEL_NOP         = 3'd0;
	localparam alu_sel_t SEL_LOGIC       = 3'd1;
	localparam alu_sel_t SEL_SHIFT       = 3'd2;
	localparam alu_sel_t SEL_ARITH       = 3'd3;
	localparam alu_sel_t SEL_LOAD_STORE  = 3'd4;
	localparam alu_sel_t SEL_JUMP_BRANCH = 3'd5;

	localparam br_kind_t BR_NONE = 4'd0;
	localparam br_kind_t BR_EQ   = 4'd1;
	localparam br_kind_t BR_NE   = 4'd2;
	localparam br_kind_t BR_LT   = 4'd3;
	localparam br_kind_t BR_GE   = 4'd4;
	localparam br_kind_t BR_LTU  = 4'd5;
	localparam br_kind_t BR_GEU  = 4'd6;
	localparam br_kind_t BR_JAL  = 4'd7;
	localparam br_kind_t BR_JALR = 4'd8;

	typedef struct packed {
		logic                     re;
		riscv_isa_pkg::reg_addr_t addr;
	} rf_rd_t;

	typedef struct packed {
		logic                     we;
		riscv_isa_pkg::reg_addr_t wd;
		riscv_isa_pkg::word_t     wdata;
	} fwd_src_t;

	typedef struct packed {
		fwd_src_t fwd;
		alu_op_t  alu_op; // tells a load apart from the rest
	} ex_fwd_t;

	typedef struct packed {
		alu_op_t                  alu_op;
		alu_sel_t                 alu_sel;
		rf_rd_t                   rs1;
		rf_rd_t                   rs2;
		riscv_isa_pkg::reg_addr_t wd;
		logic                     wreg;
		riscv_isa_pkg::word_t     imm;
		logic                     use_pc;
		br_kind_t                 br_kind;
	} dec_t;

	typedef struct packed {
		alu_op_t                  alu_op;
		alu_sel_t                 alu_sel;
		riscv_isa_pkg::word_t     reg1;
		riscv_isa_pkg::word_t     reg2;
		riscv_isa_pkg::reg_addr_t wd;
		logic                     wreg;
		riscv_isa_pkg::word_t     link_addr;
	} id_ex_t;

	typedef struct packed {
		logic                 taken;
		riscv_isa_pkg::word_t target;
	} branch_t;

	localparam id_ex_t ID_EX_BUBBLE = '{
		alu_op:    ALU_NOP,
		alu_sel:   SEL_NOP,
		reg1:      '0,
		reg2:      '0,
		wd:        '0,
		wreg:      1'b0,
		link_addr: '0
	};

endpackage

// ==== logic/inst_decoder.sv ====
`timescale 1ns/1ps

module inst_decoder (
	input  riscv_isa_pkg::inst_t inst_i,
	output id_stage_pkg::dec_t   dec_o
);
	import riscv_isa_pkg::*;
	import id_stage_pkg::*;

	opcode_t   opcode;
	funct3_t   f3;
	funct7_t   f7;
	reg_addr_t rd;
	reg_addr_t rs1;
	reg_addr_t rs2;
	word_t     imm_i;
	word_t     imm_u;
	word_t     shamt;
	logic      is_imm;
	logic      base_ok;
	alu_op_t   arith_op;
	alu_sel_t  arith_sel;

	assign opcode  = inst_i[6:0];
	assign f3      = inst_i[F3_LSB +: 3];
	assign f7      = inst_i[F7_LSB +: 7];
	assign rd      = inst_i[RD_LSB +: REG_ADDR_W];
	assign rs1     = inst_i[RS1_LSB +: REG_ADDR_W];
	assign rs2     = inst_i[RS2_LSB +: REG_ADDR_W];
	assign imm_i   = {{20{inst_i[31]}}, inst_i[IMM_LSB +: 12]};
	assign imm_u   = {inst_i[U_LSB +: 20], 12'b0};
	assign shamt   = word_t'(inst_i[IMM_LSB +: 5]);
	assign is_imm  = (opcode == OPC_OP_IMM);
	assign base_ok = is_imm || (f7 == F7_BASE); // funct7 is immediate bits in I-type

	// shared funct3 decode of register and immediate ALU forms
	always_comb begin
		arith_op = ALU_NOP;
		case (f3)
			F3_ADD_SUB: begin
				if (base_ok) arith_op = ALU_ADD;
				else if (f7 == F7_ALT) arith_op = ALU_SUB; // no SUBI
			end
			F3_SLL:     if (f7 == F7_BASE) arith_op = ALU_SLL;
			F3_SLT:     if (base_ok) arith_op = ALU_SLT;
			F3_SLTU:    if (base_ok) arith_op = ALU_SLTU;
			F3_XOR:     if (base_ok) arith_op = ALU_XOR;
			F3_SRL_SRA: begin
				if (f7 == F7_BASE) arith_op = ALU_SRL;
				else if (f7 == F7_ALT) arith_op = ALU_SRA;
			end
			F3_OR:      if (base_ok) arith_op = ALU_OR;
			F3_AND:     if (base_ok) arith_op = ALU_AND;
		endcase
	end

	always_comb begin
		case (arith_op)
			ALU_OR, ALU_AND, ALU_XOR: arith_sel = SEL_LOGIC;
			ALU_SLL, ALU_SRL, ALU_SRA: arith_sel = SEL_SHIFT;
			ALU_NOP: arith_sel = SEL_NOP;
			default: arith_sel = SEL_ARITH;
		endcase
	end

	always_comb begin
		// nop bundle unless an encoding below matches
		dec_o.alu_op  = ALU_NOP;
		dec_o.alu_sel = SEL_NOP;
		dec_o.rs1     = '{re: 1'b0, addr: '0};
		dec_o.rs2     = '{re: 1'b0, addr: '0};
		dec_o.wd      = '0;
		dec_o.wreg    = 1'b0;
		dec_o.imm     = '0;
		dec_o.use_pc  = 1'b0;
		dec_o.br_kind = BR_NONE;
		case (opcode)
			OPC_OP, OPC_OP_IMM: begin
				if (arith_op != ALU_NOP) begin
					dec_o.alu_op  = arith_op;
					dec_o.alu_sel = arith_sel;
					dec_o.rs1     = '{re: 1'b1, addr: rs1};
					if (!is_imm) dec_o.rs2 = '{re: 1'b1, addr: rs2};
					else if (arith_sel == SEL_SHIFT) dec_o.imm = shamt;
					else dec_o.imm = imm_i;
					dec_o.wd   = rd;
					dec_o.wreg = 1'b1;
				end
			end
			OPC_LUI: begin
				dec_o.alu_op  = ALU_OR; // x0 | imm
				dec_o.alu_sel = SEL_LOGIC;
				dec_o.rs1     = '{re: 1'b1, addr: '0};
				dec_o.imm     = imm_u;
				dec_o.wd      = rd;
				dec_o.wreg    = 1'b1;
			end
			OPC_AUIPC: begin
				dec_o.alu_op  = ALU_ADD; // pc + imm
				dec_o.alu_sel = SEL_ARITH;
				dec_o.use_pc  = 1'b1;
				dec_o.imm     = imm_u;
				dec_o.wd      = rd;
				dec_o.wreg    = 1'b1;
			end
			OPC_LOAD: begin
				case (f3)
					F3_LB:   dec_o.alu_op = ALU_LB;
					F3_LH:   dec_o.alu_op = ALU_LH;
					F3_LW:   dec_o.alu_op = ALU_LW;
					F3_LBU:  dec_o.alu_op = ALU_LBU;
					F3_LHU:  dec_o.alu_op = ALU_LHU;
					default: dec_o.alu_op = ALU_NOP;
				endcase
				if (dec_o.alu_op != ALU_NOP) begin
					dec_o.alu_sel = SEL_LOAD_STORE;
					dec_o.rs1     = '{re: 1'b1, addr: rs1}; // base
					dec_o.imm     = imm_i;
					dec_o.wd      = rd;
					dec_o.wreg    = 1'b1;
				end
			end
			OPC_STORE: begin
				case (f3)
					F3_SB:   dec_o.alu_op = ALU_SB;
					F3_SH:   dec_o.alu_op = ALU_SH;
					F3_SW:   dec_o.alu_op = ALU_SW;
					default: dec_o.alu_op = ALU_NOP;
				endcase
				if (dec_o.alu_op != ALU_NOP) begin
					dec_o.alu_sel = SEL_LOAD_STORE;
					dec_o.rs1     = '{re: 1'b1, addr: rs1};
					dec_o.rs2     = '{re: 1'b1, addr: rs2}; // store data
				end
			end
			OPC_BRANCH: begin
				case (f3)
					F3_BEQ:  {dec_o.alu_op, dec_o.br_kind} = {ALU_BEQ, BR_EQ};
					F3_BNE:  {dec_o.alu_op, dec_o.br_kind} = {ALU_BNE, BR_NE};
					F3_BLT:  {dec_o.alu_op, dec_o.br_kind} = {ALU_BLT, BR_LT};
					F3_BGE:  {dec_o.alu_op, dec_o.br_kind} = {ALU_BGE, BR_GE};
					F3_BLTU: {dec_o.alu_op, dec_o.br_kind} = {ALU_BLTU, BR_LTU};
					F3_BGEU: {dec_o.alu_op, dec_o.br_kind} = {ALU_BGEU, BR_GEU};
					default: {dec_o.alu_op, dec_o.br_kind} = {ALU_NOP, BR_NONE};
				endcase
				if (dec_o.alu_op != ALU_NOP) begin
					dec_o.alu_sel = SEL_JUMP_BRANCH;
					dec_o.rs1     = '{re: 1'b1, addr: rs1};
					dec_o.rs2     = '{re: 1'b1, addr: rs2};
				end
			end
			OPC_JAL: begin
				dec_o.alu_op  = ALU_JAL;
				dec_o.alu_sel = SEL_JUMP_BRANCH;
				dec_o.wd      = LINK_REG;
				dec_o.wreg    = 1'b1;
				dec_o.br_kind = BR_JAL;
			end
			OPC_JALR: begin
				if (f3 == F3_JALR) begin
					dec_o.alu_op  = ALU_JALR;
					dec_o.alu_sel = SEL_JUMP_BRANCH;
					dec_o.rs1     = '{re: 1'b1, addr: rs1};
					dec_o.imm     = imm_i; // offset added in the branch unit
					dec_o.wd      = LINK_REG;
					dec_o.wreg    = 1'b1;
					dec_o.br_kind = BR_JALR;
				end
			end
			default: ;
		endcase
	end

endmodule

// ==== logic/operand_bypass.sv ====
`timescale 1ns/1ps

module operand_bypass (
	input  id_stage_pkg::rf_rd_t   rd_i,
	input  riscv_isa_pkg::word_t   imm_i,
	input  logic                   use_pc_i,
	input  riscv_isa_pkg::word_t   pc_i,
	input  riscv_isa_pkg::word_t   rf_data_i,
	input  id_stage_pkg::ex_fwd_t  ex_fwd_i,
	input  id_stage_pkg::fwd_src_t mem_fwd_i,
	output riscv_isa_pkg::word_t   operand_o,
	output logic                   hazard_o
);
	import id_stage_pkg::*;

	logic ex_hit;
	logic mem_hit;
	logic ex_is_load;

	assign ex_hit  = ex_fwd_i.fwd.we && (ex_fwd_i.fwd.wd == rd_i.addr);
	assign mem_hit = mem_fwd_i.we && (mem_fwd_i.wd == rd_i.addr);

	assign ex_is_load = ex_fwd_i.alu_op inside {ALU_LB, ALU_LH, ALU_LBU, ALU_LHU, ALU_LW};

	// load data not ready until mem, so hold this instruction a cycle
	assign hazard_o = rd_i.re && ex_is_load && (ex_fwd_i.fwd.wd == rd_i.addr);

	always_comb begin
		if (use_pc_i)
			operand_o = pc_i;
		else if (!rd_i.re)
			operand_o = imm_i;
		else if (ex_hit)
			operand_o = ex_fwd_i.fwd.wdata; // youngest result wins
		else if (mem_hit)
			operand_o = mem_fwd_i.wdata;
		else
			operand_o = rf_data_i;
	end

endmodule

// ==== logic/branch_unit.sv ====
`timescale 1ns/1ps

module branch_unit (
	input  riscv_isa_pkg::word_t   pc_i,
	input  id_stage_pkg::br_kind_t kind_i,
	input  riscv_isa_pkg::word_t   imm_i,
	input  riscv_isa_pkg::inst_t   inst_i,
	input  riscv_isa_pkg::word_t   op1_i,
	input  riscv_isa_pkg::word_t   op2_i,
	output id_stage_pkg::branch_t  branch_o,
	output riscv_isa_pkg::word_t   link_o
);
	import riscv_isa_pkg::*;
	import id_stage_pkg::*;

	word_t b_off;
	word_t j_off;
	word_t target;
	logic  taken;

	// offsets are in units of 2 bytes, bit 0 implied zero
	assign b_off = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
	assign j_off = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

	always_comb begin
		taken  = 1'b0;
		target = pc_i + b_off;
		case (kind_i)
			BR_EQ:   taken = (op1_i == op2_i);
			BR_NE:   taken = (op1_i != op2_i);
			BR_LT:   taken = ($signed(op1_i) < $signed(op2_i));
			BR_GE:   taken = ($signed(op1_i) >= $signed(op2_i));
			BR_LTU:  taken = (op1_i < op2_i);
			BR_GEU:  taken = (op1_i >= op2_i);
			BR_JAL: begin
				taken  = 1'b1;
				target = pc_i + j_off;
			end
			BR_JALR: begin
				taken  = 1'b1;
				target = (op1_i + imm_i) & ~word_t'(1); // base is the bypassed rs1
			end
			default: taken = 1'b0;
		endcase
	end

	assign branch_o.taken  = taken;
	assign branch_o.target = taken ? target : '0;

	assign link_o = (kind_i == BR_JAL || kind_i == BR_JALR) ? pc_i + INST_BYTES : '0;

endmodule

// ==== logic/id_ex_reg.sv ====
`timescale 1ns/1ps

module id_ex_reg (
	input  logic                 clk_i,
	input  logic                 arst_n_i,
	input  id_stage_pkg::dec_t   dec_i,
	input  riscv_isa_pkg::word_t op1_i,
	input  riscv_isa_pkg::word_t op2_i,
	input  riscv_isa_pkg::word_t link_i,
	input  logic                 hazard1_i,
	input  logic                 hazard2_i,
	output id_stage_pkg::id_ex_t id_ex_o,
	output logic                 stall_o
);
	import id_stage_pkg::*;

	assign stall_o = hazard1_i | hazard2_i;

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			id_ex_o <= ID_EX_BUBBLE;
		end else if (stall_o) begin
			id_ex_o <= ID_EX_BUBBLE; // fetch holds, execute sees a nop
		end else begin
			id_ex_o.alu_op    <= dec_i.alu_op;
			id_ex_o.alu_sel   <= dec_i.alu_sel;
			id_ex_o.reg1      <= op1_i;
			id_ex_o.reg2      <= op2_i;
			id_ex_o.wd        <= dec_i.wd;
			id_ex_o.wreg      <= dec_i.wreg;
			id_ex_o.link_addr <= link_i;
		end
	end

endmodule

// ==== logic/id_stage.sv ====
`timescale 1ns/1ps

module id_stage (
	input  logic                   clk_i,
	input  logic                   arst_n_i,
	input  riscv_isa_pkg::word_t   pc_i,
	input  riscv_isa_pkg::inst_t   inst_i,
	input  id_stage_pkg::ex_fwd_t  ex_fwd_i,
	input  id_stage_pkg::fwd_src_t mem_fwd_i,
	input  riscv_isa_pkg::word_t   rf_data1_i,
	input  riscv_isa_pkg::word_t   rf_data2_i,
	output id_stage_pkg::rf_rd_t   rf_rd1_o,
	output id_stage_pkg::rf_rd_t   rf_rd2_o,
	output id_stage_pkg::id_ex_t   id_ex_o,
	output id_stage_pkg::branch_t  branch_o,
	output logic                   stall_o
);
	import riscv_isa_pkg::*;
	import id_stage_pkg::*;

	dec_t  dec;
	word_t op1;
	word_t op2;
	word_t link;
	logic  hazard1;
	logic  hazard2;

	inst_decoder i_inst_decoder (
		.inst_i (inst_i),
		.dec_o  (dec)
	);

	// register file answers in the same cycle
	assign rf_rd1_o = dec.rs1;
	assign rf_rd2_o = dec.rs2;

	operand_bypass i_bypass1 (
		.rd_i      (dec.rs1),
		.imm_i     (dec.imm),
		.use_pc_i  (dec.use_pc), // auipc
		.pc_i      (pc_i),
		.rf_data_i (rf_data1_i),
		.ex_fwd_i  (ex_fwd_i),
		.mem_fwd_i (mem_fwd_i),
		.operand_o (op1),
		.hazard_o  (hazard1)
	);

	operand_bypass i_bypass2 (
		.rd_i      (dec.rs2),
		.imm_i     (dec.imm),
		.use_pc_i  (1'b0),
		.pc_i      (pc_i),
		.rf_data_i (rf_data2_i),
		.ex_fwd_i  (ex_fwd_i),
		.mem_fwd_i (mem_fwd_i),
		.operand_o (op2),
		.hazard_o  (hazard2)
	);

	branch_unit i_branch_unit (
		.pc_i     (pc_i),
		.kind_i   (dec.br_kind),
		.imm_i    (dec.imm),
		.inst_i   (inst_i),
		.op1_i    (op1),
		.op2_i    (op2),
		.branch_o (branch_o),
		.link_o   (link)
	);

	id_ex_reg i_id_ex_reg (
		.clk_i     (clk_i),
		.arst_n_i  (arst_n_i),
		.dec_i     (dec),
		.op1_i     (op1),
		.op2_i     (op2),
		.link_i    (link),
		.hazard1_i (hazard1),
		.hazard2_i (hazard2),
		.id_ex_o   (id_ex_o),
		.stall_o   (stall_o)
	);

endmodule

// ==== dv/id_stage_ref.svh ====
`ifndef ID_STAGE_REF_SVH
`define ID_STAGE_REF_SVH

typedef struct packed {
	rf_rd_t  rd1;
	rf_rd_t  rd2;
	branch_t br;
	logic    stall;
	id_ex_t  id_ex;
} expect_t;

logic [31:0] rng_state = 32'hdb93;

function automatic logic [31:0] next_rand();
	rng_state = rng_state ^ (rng_state << 13);
	rng_state = rng_state ^ (rng_state >> 17);
	rng_state = rng_state ^ (rng_state << 5);
	return rng_state;
endfunction

function automatic alu_op_t ref_arith(funct3_t f3, funct7_t f7, logic imm_form);
	alu_op_t op;
	logic    f7_base;
	logic    f7_alt;
	f7_base = (f7 == F7_BASE);
	f7_alt  = (f7 == F7_ALT);
	case (f3)
		F3_SLL:     op = f7_base ? ALU_SLL : ALU_NOP;
		F3_SRL_SRA: op = f7_base ? ALU_SRL : (f7_alt ? ALU_SRA : ALU_NOP);
		F3_ADD_SUB: op = (imm_form || f7_base) ? ALU_ADD : (f7_alt ? ALU_SUB : ALU_NOP);
		F3_SLT:     op = ALU_SLT;
		F3_SLTU:    op = ALU_SLTU;
		F3_XOR:     op = ALU_XOR;
		F3_OR:      op = ALU_OR;
		default:    op = ALU_AND;
	endcase
	// upper bits are immediate in I-type, a real funct7 only in R-type
	if (!imm_form && !f7_base && f3 inside {F3_SLT, F3_SLTU, F3_XOR, F3_OR, F3_AND})
		op = ALU_NOP;
	return op;
endfunction

function automatic word_t pick_operand(rf_rd_t rd, logic use_pc, word_t pc, word_t imm,
		word_t rf, ex_fwd_t ex, fwd_src_t mem);
	if (use_pc)
		return pc;
	if (!rd.re)
		return imm;
	if (ex.fwd.we && ex.fwd.wd == rd.addr)
		return ex.fwd.wdata;
	if (mem.we && mem.wd == rd.addr)
		return mem.wdata;
	return rf;
endfunction

function automatic logic load_use(rf_rd_t rd, ex_fwd_t ex);
	return rd.re && (ex.fwd.wd == rd.addr) &&
		(ex.alu_op inside {ALU_LB, ALU_LH, ALU_LBU, ALU_LHU, ALU_LW});
endfunction

function automatic expect_t ref_id_stage(inst_t inst, word_t pc, ex_fwd_t ex, fwd_src_t mem,
		word_t rf1, word_t rf2);
	expect_t  e;
	opcode_t  opc;
	funct3_t  f3;
	word_t    imm_i;
	word_t    imm;
	word_t    op1;
	word_t    op2;
	word_t    target;
	logic     use_pc;
	br_kind_t kind;
	e      = '0;
	imm    = '0;
	use_pc = 1'b0;
	kind   = BR_NONE;
	opc    = inst[6:0];
	f3     = inst[14:12];
	imm_i  = {{20{inst[31]}}, inst[31:20]};
	case (opc)
		OPC_OP, OPC_OP_IMM: begin
			e.id_ex.alu_op = ref_arith(f3, inst[31:25], opc == OPC_OP_IMM);
			if (e.id_ex.alu_op != ALU_NOP) begin
				e.rd1 = '{re: 1'b1, addr: inst[19:15]};
				if (opc == OPC_OP)
					e.rd2 = '{re: 1'b1, addr: inst[24:20]};
				else if (f3 == F3_SLL || f3 == F3_SRL_SRA)
					imm = word_t'(inst[24:20]); // shamt only
				else
					imm = imm_i;
				e.id_ex.wd   = inst[11:7];
				e.id_ex.wreg = 1'b1;
			end
		end
		OPC_LUI, OPC_AUIPC: begin
			e.id_ex.alu_op = (opc == OPC_LUI) ? ALU_OR : ALU_ADD;
			e.rd1          = '{re: (opc == OPC_LUI), addr: 5'd0};
			use_pc         = (opc == OPC_AUIPC);
			imm            = {inst[31:12], 12'b0};
			e.id_ex.wd     = inst[11:7];
			e.id_ex.wreg   = 1'b1;
		end
		OPC_LOAD: begin
			case (f3)
				F3_LB:   e.id_ex.alu_op = ALU_LB;
				F3_LH:   e.id_ex.alu_op = ALU_LH;
				F3_LW:   e.id_ex.alu_op = ALU_LW;
				F3_LBU:  e.id_ex.alu_op = ALU_LBU;
				F3_LHU:  e.id_ex.alu_op = ALU_LHU;
				default: e.id_ex.alu_op = ALU_NOP;
			endcase
			if (e.id_ex.alu_op != ALU_NOP) begin
				e.rd1        = '{re: 1'b1, addr: inst[19:15]};
				imm          = imm_i;
				e.id_ex.wd   = inst[11:7];
				e.id_ex.wreg = 1'b1;
			end
		end
		OPC_STORE: begin
			case (f3)
				F3_SB:   e.id_ex.alu_op = ALU_SB;
				F3_SH:   e.id_ex.alu_op = ALU_SH;
				F3_SW:   e.id_ex.alu_op = ALU_SW;
				default: e.id_ex.alu_op = ALU_NOP;
			endcase
			if (e.id_ex.alu_op != ALU_NOP) begin
				e.rd1 = '{re: 1'b1, addr: inst[19:15]};
				e.rd2 = '{re: 1'b1, addr: inst[24:20]};
			end
		end
		OPC_BRANCH: begin
			case (f3)
				F3_BEQ:  {e.id_ex.alu_op, kind} = {ALU_BEQ, BR_EQ};
				F3_BNE:  {e.id_ex.alu_op, kind} = {ALU_BNE, BR_NE};
				F3_BLT:  {e.id_ex.alu_op, kind} = {ALU_BLT, BR_LT};
				F3_BGE:  {e.id_ex.alu_op, kind} = {ALU_BGE, BR_GE};
				F3_BLTU: {e.id_ex.alu_op, kind} = {ALU_BLTU, BR_LTU};
				F3_BGEU: {e.id_ex.alu_op, kind} = {ALU_BGEU, BR_GEU};
				default: {e.id_ex.alu_op, kind} = {ALU_NOP, BR_NONE};
			endcase
			if (kind != BR_NONE) begin
				e.rd1 = '{re: 1'b1, addr: inst[19:15]};
				e.rd2 = '{re: 1'b1, addr: inst[24:20]};
			end
		end
		OPC_JAL: begin
			e.id_ex.alu_op = ALU_JAL;
			kind           = BR_JAL;
			e.id_ex.wd     = LINK_REG;
			e.id_ex.wreg   = 1'b1;
		end
		OPC_JALR: begin
			if (f3 == F3_JALR) begin
				e.id_ex.alu_op = ALU_JALR;
				kind           = BR_JALR;
				e.rd1          = '{re: 1'b1, addr: inst[19:15]};
				imm            = imm_i;
				e.id_ex.wd     = LINK_REG;
				e.id_ex.wreg   = 1'b1;
			end
		end
		default: ;
	endcase
	case (e.id_ex.alu_op)
		ALU_NOP:                             e.id_ex.alu_sel = SEL_NOP;
		ALU_OR, ALU_AND, ALU_XOR:            e.id_ex.alu_sel = SEL_LOGIC;
		ALU_SLL, ALU_SRL, ALU_SRA:           e.id_ex.alu_sel = SEL_SHIFT;
		ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU: e.id_ex.alu_sel = SEL_ARITH;
		ALU_LB, ALU_LH, ALU_LBU, ALU_LHU, ALU_LW, ALU_SB, ALU_SH, ALU_SW:
			e.id_ex.alu_sel = SEL_LOAD_STORE;
		default:                             e.id_ex.alu_sel = SEL_JUMP_BRANCH;
	endcase
	op1     = pick_operand(e.rd1, use_pc, pc, imm, rf1, ex, mem);
	op2     = pick_operand(e.rd2, 1'b0, pc, imm, rf2, ex, mem);
	e.stall = load_use(e.rd1, ex) || load_use(e.rd2, ex);
	case (kind)
		BR_EQ:           e.br.taken = (op1 == op2);
		BR_NE:           e.br.taken = (op1 != op2);
		BR_LT:           e.br.taken = ($signed(op1) < $signed(op2));
		BR_GE:           e.br.taken = ($signed(op1) >= $signed(op2));
		BR_LTU:          e.br.taken = (op1 < op2);
		BR_GEU:          e.br.taken = (op1 >= op2);
		BR_JAL, BR_JALR: e.br.taken = 1'b1;
		default:         e.br.taken = 1'b0;
	endcase
	if (kind == BR_JAL)
		target = pc + {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
	else if (kind == BR_JALR)
		target = (op1 + imm_i) & 32'hffff_fffe;
	else
		target = pc + {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	if (e.br.taken)
		e.br.target = target;
	if (kind == BR_JAL || kind == BR_JALR)
		e.id_ex.link_addr = pc + 32'd4;
	e.id_ex.reg1 = op1;
	e.id_ex.reg2 = op2;
	if (e.stall)
		e.id_ex = '0; // bubble, every field zero
	return e;
endfunction

`endif

// ==== dv/id_stage_tb.sv ====
`timescale 1ns/1ps

module id_stage_tb;
	import riscv_isa_pkg::*;
	import id_stage_pkg::*;

	`include "id_stage_ref.svh"

	localparam int CLK_PERIOD  = 4;
	localparam int ALU_ROUNDS  = 48;
	localparam int BR_ROUNDS   = 8;
	localparam int JUMP_ROUNDS = 4;
	localparam int N_VECTORS   = ALU_ROUNDS + 12 + 6 * BR_ROUNDS + 3 + 5 + 4 * JUMP_ROUNDS;
	localparam int WATCHDOG_NS = (N_VECTORS * 4 + 50) * CLK_PERIOD;
	localparam funct3_t BR_F3 [6] = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
	localparam funct3_t LD_F3 [5] = '{F3_LB, F3_LH, F3_LW, F3_LBU, F3_LHU};

	logic     clk_i;
	logic     arst_n_i;
	word_t    pc_i;
	inst_t    inst_i;
	ex_fwd_t  ex_fwd_i;
	fwd_src_t mem_fwd_i;
	word_t    rf_data1_i;
	word_t    rf_data2_i;
	rf_rd_t   rf_rd1_o;
	rf_rd_t   rf_rd2_o;
	id_ex_t   id_ex_o;
	branch_t  branch_o;
	logic     stall_o;

	expect_t  exp_q;
	string    exp_name;
	int       applied = 0;
	int       checked = 0;

	id_stage i_id_stage (
		.clk_i      (clk_i),
		.arst_n_i   (arst_n_i),
		.pc_i       (pc_i),
		.inst_i     (inst_i),
		.ex_fwd_i   (ex_fwd_i),
		.mem_fwd_i  (mem_fwd_i),
		.rf_data1_i (rf_data1_i),
		.rf_data2_i (rf_data2_i),
		.rf_rd1_o   (rf_rd1_o),
		.rf_rd2_o   (rf_rd2_o),
		.id_ex_o    (id_ex_o),
		.branch_o   (branch_o),
		.stall_o    (stall_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
	end

	task automatic fail_run(string line);
		$display("%s", line);
		$display("Some tests failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_rd(string name, rf_rd_t exp, rf_rd_t act);
		if (act !== exp)
			fail_run($sformatf("ERR %s expected %h actual %h", name, exp, act));
	endtask

	task automatic check_branch(string name, branch_t exp, branch_t act);
		if (act !== exp)
			fail_run($sformatf("ERR %s expected %h actual %h", name, exp, act));
	endtask

	task automatic check_stall(string name, bit exp, logic act);
		if (act !== exp)
			fail_run($sformatf("ERR %s expected %b actual %b", name, exp, act));
	endtask

	task automatic check_id_ex(string name, id_ex_t exp, id_ex_t act);
		if (act !== exp)
			fail_run($sformatf("ERR %s expected %h actual %h", name, exp, act));
	endtask

	function automatic inst_t r_type_inst(funct7_t f7, reg_addr_t rs2, reg_addr_t rs1,
			funct3_t f3, reg_addr_t rd, opcode_t opc);
		return {f7, rs2, rs1, f3, rd, opc};
	endfunction

	function automatic inst_t i_type_inst(logic [11:0] imm, reg_addr_t rs1, funct3_t f3,
			reg_addr_t rd, opcode_t opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic inst_t s_type_inst(logic [11:0] imm, reg_addr_t rs2, reg_addr_t rs1,
			funct3_t f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
	endfunction

	function automatic inst_t b_type_inst(logic [12:0] off, reg_addr_t rs2, reg_addr_t rs1,
			funct3_t f3);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
	endfunction

	function automatic inst_t j_type_inst(logic [20:0] off, reg_addr_t rd);
		return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
	endfunction

	task automatic drive_vector(string name, inst_t inst, word_t pc, ex_fwd_t ex,
			fwd_src_t mem, word_t rf1, word_t rf2);
		@(negedge clk_i);
		inst_i     = inst;
		pc_i       = pc;
		ex_fwd_i   = ex;
		mem_fwd_i  = mem;
		rf_data1_i = rf1;
		rf_data2_i = rf2;
		exp_q      = ref_id_stage(inst, pc, ex, mem, rf1, rf2);
		exp_name   = name;
		applied++;
	endtask

	// comb outputs before the edge and the registered bundle just after it
	initial begin
		forever begin
			@(posedge clk_i);
			if (checked != applied) begin
				check_rd({exp_name, "/rd1"}, exp_q.rd1, rf_rd1_o);
				check_rd({exp_name, "/rd2"}, exp_q.rd2, rf_rd2_o);
				check_branch({exp_name, "/branch"}, exp_q.br, branch_o);
				check_stall({exp_name, "/stall"}, exp_q.stall, stall_o);
				#1;
				check_id_ex({exp_name, "/id_ex"}, exp_q.id_ex, id_ex_o);
				checked++;
			end
		end
	end

	initial begin
		#(WATCHDOG_NS);
		fail_run("timeout: the test sequence did not finish in time");
	end

	initial begin
		inst_t     inst;
		word_t     a;
		word_t     b;
		word_t     off;
		word_t     pc;
		funct7_t   f7;
		ex_fwd_t   ex;
		fwd_src_t  mem;
		arst_n_i   = 1'b0;
		pc_i       = '0;
		inst_i     = '0;
		ex_fwd_i   = '0;
		mem_fwd_i  = '0;
		rf_data1_i = '0;
		rf_data2_i = '0;
		repeat (3) @(posedge clk_i);
		@(negedge clk_i);
		arst_n_i = 1'b1;
		check_id_ex("reset", '0, id_ex_o);
		check_stall("reset", 1'b0, stall_o);

		ex  = '0;
		mem = '0;
		for (int i = 0; i < ALU_ROUNDS; i++) begin
			a    = next_rand();
			f7   = a[30] ? a[31:25] : (a[31] ? F7_ALT : F7_BASE); // mostly legal funct7
			inst = {f7, a[24:7], (i % 2 == 1) ? OPC_OP_IMM : OPC_OP};
			pc   = next_rand() & 32'hffff_fffc;
			b    = next_rand();
			drive_vector("alu", inst, pc, ex, mem, b, next_rand());
		end
		drive_vector("bad_shift", i_type_inst({F7_ALT, 5'd3}, 5'd4, F3_SLL, 5'd5, OPC_OP_IMM),
			32'h100, ex, mem, 32'h11, 32'h22);
		drive_vector("bad_shift", i_type_inst({7'b0000001, 5'd9}, 5'd4, F3_SRL_SRA, 5'd5,
			OPC_OP_IMM), 32'h104, ex, mem, 32'h11, 32'h22);
		drive_vector("bad_shift", r_type_inst(F7_ALT, 5'd6, 5'd4, F3_SLL, 5'd5, OPC_OP),
			32'h108, ex, mem, 32'h11, 32'h22);
		drive_vector("bad_shift", r_type_inst(7'b0100001, 5'd6, 5'd4, F3_SRL_SRA, 5'd5, OPC_OP),
			32'h10c, ex, mem, 32'h11, 32'h22);

		// forward priority with rs1 = x3 and rs2 = x7
		inst = r_type_inst(F7_BASE, 5'd7, 5'd3, F3_ADD_SUB, 5'd9, OPC_OP);
		ex   = '{fwd: '{we: 1'b1, wd: 5'd3, wdata: next_rand()}, alu_op: ALU_ADD};
		mem  = '{we: 1'b1, wd: 5'd3, wdata: next_rand()};
		drive_vector("fwd_both", inst, 32'h200, ex, mem, next_rand(), 32'h77);
		ex.fwd.wd = 5'd12;
		mem.wd    = 5'd7;
		drive_vector("fwd_mem", inst, 32'h204, ex, mem, 32'h33, next_rand());
		ex.fwd.we = 1'b0;
		ex.fwd.wd = 5'd3;
		mem.we    = 1'b0;
		drive_vector("fwd_none", inst, 32'h208, ex, mem, 32'h33, 32'h77);
		ex.fwd.we = 1'b1;
		ex.fwd.wd = 5'd7; // rs2 field of addi is immediate bits
		drive_vector("fwd_imm", i_type_inst(12'h7a7, 5'd3, F3_ADD_SUB, 5'd9, OPC_OP_IMM),
			32'h20c, ex, mem, 32'h33, 32'h77);

		// load-use stall, then the held instruction takes the memory forward
		ex  = '{fwd: '{we: 1'b1, wd: 5'd3, wdata: 32'hdead}, alu_op: ALU_LW};
		mem = '0;
		drive_vector("load_rs1", inst, 32'h300, ex, mem, 32'h33, 32'h77);
		ex  = '0;
		mem = '{we: 1'b1, wd: 5'd3, wdata: 32'h1234_5678};
		drive_vector("load_rs1_held", inst, 32'h300, ex, mem, 32'h33, 32'h77);
		ex  = '{fwd: '{we: 1'b1, wd: 5'd7, wdata: 32'hbeef}, alu_op: ALU_LBU};
		drive_vector("load_rs2", inst, 32'h304, ex, mem, 32'h33, 32'h77);
		ex.alu_op = ALU_SUB;
		drive_vector("alu_no_stall", inst, 32'h308, ex, mem, 32'h33, 32'h77);

		ex  = '0;
		mem = '0;
		for (int k = 0; k < 6; k++) begin
			for (int i = 0; i < BR_ROUNDS; i++) begin
				a    = next_rand();
				b    = (i % 4 == 0) ? a : next_rand();
				off  = next_rand();
				inst = b_type_inst(off[12:0] & 13'h1ffe, 5'd7, 5'd3, BR_F3[k]);
				pc   = next_rand() & 32'hffff_fffc;
				drive_vector("branch", inst, pc, ex, mem, a, b);
			end
		end
		for (int k = 0; k < 3; k++) begin
			off  = next_rand();
			inst = s_type_inst(off[11:0], 5'd8, 5'd2, funct3_t'(k)); // sb, sh, sw
			drive_vector("store", inst, 32'h400, ex, mem, next_rand(), next_rand());
		end
		for (int k = 0; k < 5; k++) begin
			off  = next_rand();
			inst = i_type_inst(off[11:0], 5'd2, LD_F3[k], 5'd8, OPC_LOAD);
			drive_vector("load", inst, 32'h404, ex, mem, next_rand(), next_rand());
		end

		for (int i = 0; i < JUMP_ROUNDS; i++) begin
			pc  = next_rand() & 32'hffff_fffc;
			off = next_rand();
			// rd is not x1 here, wd still names the link register
			drive_vector("jal", j_type_inst(off[20:0] & 21'h1ffffe, 5'd6), pc, ex, mem,
				next_rand(), next_rand());
			ex  = '{fwd: '{we: i[0], wd: 5'd5, wdata: next_rand()}, alu_op: ALU_ADD};
			off = next_rand();
			drive_vector("jalr", i_type_inst(off[11:0], 5'd5, F3_JALR, 5'd9, OPC_JALR), pc,
				ex, mem, next_rand(), next_rand());
			ex = '0;
			a  = next_rand();
			drive_vector("lui", {a[31:12], 5'd10, OPC_LUI}, pc, ex, mem, 32'h0, next_rand());
			drive_vector("auipc", {a[19:0], 5'd11, OPC_AUIPC}, pc, ex, mem, next_rand(), a);
		end

		@(negedge clk_i);
		wait (checked == applied);
		$display("All tests passed");
		$finish;
	end

endmodule

// ==== id_stage.f ====
+incdir+dv
logic/riscv_isa_pkg.sv
logic/id_stage_pkg.sv
logic/inst_decoder.sv
logic/operand_bypass.sv
logic/branch_unit.sv
logic/id_ex_reg.sv
logic/id_stage.sv
dv/id_stage_tb.sv

// ==== run.sh ====
#!/bin/sh
# build with verilator, then let the pass line decide the exit status
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/1ps -f id_stage.f --top-module id_stage_tb \
	-o id_stage_sim &&
./obj_dir/id_stage_sim | tee /dev/stderr | grep -q "All tests passed" &&
echo "PASS" || { echo "FAIL"; exit 1; }
